/* touch_spi_pkg.sv */
`default_nettype none

package touch_spi_pkg;

	// Serial clock half period in cclk cycles
	localparam int unsigned TOUCH_CLK_DIV = 25;

	// Bit slot map of one frame, each slot opens at a falling edge
	localparam int unsigned FRAME_LAST_SLOT = 24;
	localparam int unsigned CMD_LAST_SLOT = 7;
	localparam int unsigned RESP_FIRST_SLOT = 9;
	localparam int unsigned RESP_LAST_SLOT = 20;

	// Frames per channel, only the last conversion is kept
	localparam int unsigned REPETITIONS = 16;

	// Channel address bits A2..A0 of the command byte
	typedef enum logic [2:0] {
		CH_X = 3'b101,
		CH_Y = 3'b001,
		CH_Z = 3'b011
	} touch_channel_e;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_FRAME,
		SEQ_NEXT,
		SEQ_HANDOFF,
		SEQ_STALL
	} touch_seq_e;

	// Command byte, MSB goes out first
	typedef struct packed {
		logic           start;
		touch_channel_e channel;
		logic           mode;
		logic           single_ended;
		logic [1:0]     power_down;
	} touch_cmd_t;

endpackage

`default_nettype wire

/* touch_coord_pkg.sv */
`default_nettype none

package touch_coord_pkg;

	// One finished coordinate set
	typedef struct packed {
		logic [11:0] x;
		logic [11:0] y;
		logic [11:0] z;
	} touch_sample_t;

	// Calibration window, raw values below MIN read as 0
	localparam logic [11:0] X_ADJ_MIN = 12'h096;
	localparam logic [11:0] X_ADJ_MAX = 12'hF6E;
	localparam logic [11:0] Y_ADJ_MIN = 12'h12C;
	localparam logic [11:0] Y_ADJ_MAX = 12'hED8;

endpackage

`default_nettype wire

/* touch_sclk_gen.sv */
`default_nettype none

module touch_sclk_gen (
	input  logic cclk,
	input  logic counter_rst,
	input  logic run,
	output logic touch_clk,
	output logic sclk_rise,
	output logic sclk_fall
);
	import touch_spi_pkg::*;

	logic [4:0] div_cnt;
	logic       div_wrap;

	// Last cycle of a half period, touch_clk toggles at its end
	assign div_wrap = run && (div_cnt == 5'(TOUCH_CLK_DIV - 1));

	// Strobes lead the toggle so other blocks switch on the same edge
	assign sclk_rise = div_wrap && !touch_clk;
	assign sclk_fall = div_wrap && touch_clk;

	always_ff @(posedge cclk) begin
		if (counter_rst || !run) begin
			div_cnt <= '0;
			touch_clk <= 1'b0;
		end else if (div_wrap) begin
			div_cnt <= '0;
			touch_clk <= !touch_clk;
		end else begin
			div_cnt <= div_cnt + 5'd1;
		end
	end

endmodule

`default_nettype wire

/* touch_frame_counter.sv */
`default_nettype none

module touch_frame_counter (
	input  logic       cclk,
	input  logic       counter_rst,
	input  logic       run,
	input  logic       sclk_fall,
	output logic [4:0] slot,
	output logic       frame_end
);
	import touch_spi_pkg::*;

	// Low until the first fall strobe of a run, which opens slot 0
	logic armed;

	assign frame_end = sclk_fall && (!armed || (slot == 5'(FRAME_LAST_SLOT)));

	always_ff @(posedge cclk) begin
		if (counter_rst || !run) begin
			slot <= '0;
			armed <= 1'b0;
		end else if (sclk_fall) begin
			armed <= 1'b1;
			if (frame_end) begin
				slot <= '0;
			end else begin
				slot <= slot + 5'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* touch_cmd_shifter.sv */
`default_nettype none

module touch_cmd_shifter (
	input  logic                     cclk,
	input  logic                     counter_rst,
	input  touch_spi_pkg::touch_cmd_t cmd,
	input  logic                     load,
	input  logic                     sclk_fall,
	input  logic [4:0]               slot,
	output logic                     touch_dout
);
	import touch_spi_pkg::*;

	logic [7:0] shreg;
	logic [7:0] out_bits;

	// Load coincides with the fall that opens slot 0
	assign out_bits = load ? cmd : shreg;

	always_ff @(posedge cclk) begin
		if (counter_rst) begin
			shreg <= '0;
			touch_dout <= 1'b0;
		end else if (sclk_fall) begin
			// slot still names the slot that is ending here
			if (load || (slot < 5'(CMD_LAST_SLOT))) begin
				touch_dout <= out_bits[7];
				shreg <= {out_bits[6:0], 1'b0};
			end else begin
				touch_dout <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* touch_resp_shifter.sv */
`default_nettype none

module touch_resp_shifter (
	input  logic        cclk,
	input  logic        counter_rst,
	input  logic        touch_din,
	input  logic        sclk_rise,
	input  logic [4:0]  slot,
	output logic [11:0] result
);
	import touch_spi_pkg::*;

	logic in_window;

	// Data slots only, the busy slot and idle tail are skipped
	assign in_window = (slot >= 5'(RESP_FIRST_SLOT)) && (slot <= 5'(RESP_LAST_SLOT));

	always_ff @(posedge cclk) begin
		if (counter_rst) begin
			result <= '0;
		end else if (sclk_rise && in_window) begin
			// MSB arrives first
			result <= {result[10:0], touch_din};
		end
	end

endmodule

`default_nettype wire

/* touch_sample_port.sv */
`default_nettype none

module touch_sample_port (
	input  logic                          cclk,
	input  logic                          counter_rst,
	input  logic                          raw_valid,
	input  logic                          sample_ack,
	input  touch_coord_pkg::touch_sample_t raw,
	output touch_coord_pkg::touch_sample_t sample,
	output logic                          sample_req,
	output logic                          port_free
);
	import touch_coord_pkg::*;

	typedef enum logic [1:0] {
		PORT_EMPTY,
		PORT_REQ,
		PORT_DRAIN
	} port_state_e;

	port_state_e   state;
	touch_sample_t calibrated;

	function automatic logic [11:0] calibrate(
		input logic [11:0] value,
		input logic [11:0] adj_min,
		input logic [11:0] adj_max
	);
		logic [11:0] shifted;
		shifted = value - adj_min;
		if (value < adj_min) begin
			return 12'd0;
		end
		return (shifted > adj_max) ? adj_max : shifted;
	endfunction

	assign calibrated.x = calibrate(raw.x, X_ADJ_MIN, X_ADJ_MAX);
	assign calibrated.y = calibrate(raw.y, Y_ADJ_MIN, Y_ADJ_MAX);
	// Pressure is not windowed
	assign calibrated.z = raw.z;

	assign sample_req = (state == PORT_REQ);
	assign port_free = (state == PORT_EMPTY);

	// Four-phase handshake
	always_ff @(posedge cclk) begin
		if (counter_rst) begin
			state <= PORT_EMPTY;
		end else begin
			case (state)
				PORT_EMPTY: begin
					if (raw_valid) begin
						state <= PORT_REQ;
					end
				end
				PORT_REQ: begin
					if (sample_ack) begin
						state <= PORT_DRAIN;
					end
				end
				PORT_DRAIN: begin
					if (!sample_ack) begin
						state <= PORT_EMPTY;
					end
				end
				default: state <= PORT_EMPTY;
			endcase
		end
	end

	// Held until the consumer has released the handshake
	always_ff @(posedge cclk) begin
		if ((state == PORT_EMPTY) && raw_valid) begin
			sample <= calibrated;
		end
	end

endmodule

`default_nettype wire

/* touchpad_controller.sv */
`default_nettype none

module touchpad_controller (
	input  logic                          cclk,
	input  logic                          counter_rst,
	input  logic                          touch_din,
	input  logic                          port_free,
	output logic                          touch_clk,
	output logic                          touch_csb,
	output logic                          touch_dout,
	output logic                          raw_valid,
	output touch_coord_pkg::touch_sample_t raw
);
	import touch_spi_pkg::*;

	touch_seq_e     state;
	touch_channel_e channel;
	logic [3:0]     rep;
	logic           last_rep;
	logic           run;
	logic           sclk_rise;
	logic           sclk_fall;
	logic [4:0]     slot;
	logic           frame_end;
	logic           cmd_load;
	touch_cmd_t     cmd;
	logic [11:0]    result;

	function automatic touch_channel_e next_channel(input touch_channel_e ch);
		case (ch)
			CH_X: return CH_Y;
			CH_Y: return CH_Z;
			default: return CH_X;
		endcase
	endfunction

	// Chip is selected for as long as the serial clock runs
	assign touch_csb = !run;

	assign last_rep = (rep == 4'(REPETITIONS - 1));

	// 12-bit single-ended conversion, power-down bits left at 00
	assign cmd = '{start: 1'b1, channel: channel, mode: 1'b0,
		single_ended: 1'b1, power_down: 2'b00};

	// No new frame when the sweep ends against a busy port
	assign cmd_load = frame_end && !((state == SEQ_HANDOFF) && !port_free);

	touch_sclk_gen sclk_gen_i (
		.cclk        (cclk),
		.counter_rst (counter_rst),
		.run         (run),
		.touch_clk   (touch_clk),
		.sclk_rise   (sclk_rise),
		.sclk_fall   (sclk_fall)
	);

	touch_frame_counter frame_counter_i (
		.cclk        (cclk),
		.counter_rst (counter_rst),
		.run         (run),
		.sclk_fall   (sclk_fall),
		.slot        (slot),
		.frame_end   (frame_end)
	);

	touch_cmd_shifter cmd_shifter_i (
		.cclk        (cclk),
		.counter_rst (counter_rst),
		.cmd         (cmd),
		.load        (cmd_load),
		.sclk_fall   (sclk_fall),
		.slot        (slot),
		.touch_dout  (touch_dout)
	);

	touch_resp_shifter resp_shifter_i (
		.cclk        (cclk),
		.counter_rst (counter_rst),
		.touch_din   (touch_din),
		.sclk_rise   (sclk_rise),
		.slot        (slot),
		.result      (result)
	);

	always_ff @(posedge cclk) begin
		if (counter_rst) begin
			state <= SEQ_IDLE;
			channel <= CH_X;
			rep <= '0;
			run <= 1'b0;
			raw_valid <= 1'b0;
		end else begin
			raw_valid <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					channel <= CH_X;
					rep <= '0;
					run <= 1'b1;
					state <= SEQ_FRAME;
				end
				SEQ_FRAME: begin
					// Fall that opens slot 21, the result is complete
					if (sclk_fall && (slot == 5'(RESP_LAST_SLOT))) begin
						state <= SEQ_NEXT;
					end
				end
				SEQ_NEXT: begin
					if (last_rep) begin
						rep <= '0;
						channel <= next_channel(channel);
						state <= (channel == CH_Z) ? SEQ_HANDOFF : SEQ_FRAME;
					end else begin
						rep <= rep + 4'd1;
						state <= SEQ_FRAME;
					end
				end
				SEQ_HANDOFF: begin
					if (frame_end) begin
						if (port_free) begin
							raw_valid <= 1'b1;
							state <= SEQ_FRAME;
						end else begin
							run <= 1'b0;
							state <= SEQ_STALL;
						end
					end
				end
				SEQ_STALL: begin
					// Stale sweep is dropped, a fresh one starts
					if (port_free) begin
						state <= SEQ_IDLE;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// Keep the 16th conversion of each channel
	always_ff @(posedge cclk) begin
		if ((state == SEQ_NEXT) && last_rep) begin
			case (channel)
				CH_X: raw.x <= result;
				CH_Y: raw.y <= result;
				default: raw.z <= result;
			endcase
		end
	end

endmodule

`default_nettype wire

/* touch_subsystem.sv */
`default_nettype none

module touch_subsystem (
	input  logic                          cclk,
	input  logic                          counter_rst,
	input  logic                          touch_din,
	input  logic                          sample_ack,
	output logic                          touch_clk,
	output logic                          touch_csb,
	output logic                          touch_dout,
	output logic                          sample_req,
	output touch_coord_pkg::touch_sample_t sample
);
	import touch_coord_pkg::*;

	touch_sample_t raw;
	logic          raw_valid;
	logic          port_free;

	touchpad_controller controller_i (
		.cclk        (cclk),
		.counter_rst (counter_rst),
		.touch_din   (touch_din),
		.port_free   (port_free),
		.touch_clk   (touch_clk),
		.touch_csb   (touch_csb),
		.touch_dout  (touch_dout),
		.raw_valid   (raw_valid),
		.raw         (raw)
	);

	touch_sample_port sample_port_i (
		.cclk        (cclk),
		.counter_rst (counter_rst),
		.raw_valid   (raw_valid),
		.sample_ack  (sample_ack),
		.raw         (raw),
		.sample      (sample),
		.sample_req  (sample_req),
		.port_free   (port_free)
	);

endmodule

`default_nettype wire

/* tb_touch_panel.sv */
`default_nettype none

module tb_touch_panel (
	input  logic                      cclk,
	input  logic                      touch_clk,
	input  logic                      touch_csb,
	input  logic                      touch_dout,
	output logic                      touch_din,
	output logic                      frame_logged,
	output touch_spi_pkg::touch_cmd_t frame_cmd,
	output logic [11:0]               frame_value
);
	import touch_spi_pkg::*;
	import touch_coord_pkg::*;

	integer      seed = 32'h9f35;
	int          slot = -1;
	logic        prev_clk = 1'b0;
	logic [7:0]  cmd_bits = '0;
	logic [11:0] shift = '0;
	logic [11:0] conv = '0;
	logic        din_q = 1'b0;
	logic        logged_q = 1'b0;
	touch_cmd_t  cmd_q = '0;
	logic [11:0] value_q = '0;

	assign touch_din = din_q;
	assign frame_logged = logged_q;
	assign frame_cmd = cmd_q;
	assign frame_value = value_q;

	// A quarter each below the window, at its lower edge, near full scale and anywhere.
	// The window reaches past full scale, so the top end is the far limit
	function automatic logic [11:0] draw_value(input touch_channel_e ch);
		logic [11:0] lo;
		logic [11:0] pick;
		int          mode;
		lo = (ch == CH_Y) ? Y_ADJ_MIN : X_ADJ_MIN;
		mode = $random(seed) & 3;
		pick = 12'($random(seed));
		if ((ch == CH_Z) || (mode == 3)) begin
			return pick;
		end
		if (mode == 0) begin
			return pick % lo;
		end
		if (mode == 1) begin
			return lo - 12'd1 + (pick % 12'd3);
		end
		return 12'hFFF - (pick % 12'd16);
	endfunction

	// Edges of touch_clk are seen one cclk after they happen
	always @(posedge cclk) begin
		logged_q <= 1'b0;
		if (touch_csb) begin
			slot = -1;
			din_q <= 1'b0;
		end else if (prev_clk && !touch_clk) begin
			slot = (slot == int'(FRAME_LAST_SLOT)) ? 0 : slot + 1;
			if (slot == int'(RESP_FIRST_SLOT)) begin
				// Command is complete, answer with a fresh conversion
				conv = draw_value(touch_channel_e'(cmd_bits[6:4]));
				shift = conv;
				din_q <= conv[11];
				cmd_q <= touch_cmd_t'(cmd_bits);
				value_q <= conv;
				logged_q <= 1'b1;
			end else if ((slot > int'(RESP_FIRST_SLOT)) && (slot <= int'(RESP_LAST_SLOT))) begin
				shift = {shift[10:0], 1'b0};
				din_q <= shift[11];
			end else begin
				din_q <= 1'b0;
			end
		end else if (!prev_clk && touch_clk && (slot >= 0) && (slot <= int'(CMD_LAST_SLOT))) begin
			// Command bits are taken on the rising edge, MSB first
			cmd_bits = {cmd_bits[6:0], touch_dout};
		end
		prev_clk = touch_clk;
	end

endmodule

`default_nettype wire

/* tb_touch_subsystem.sv */
`default_nettype none

module tb_touch_subsystem;
	import touch_spi_pkg::*;
	import touch_coord_pkg::*;

	// Three channels of 16 frames, each frame 25 serial periods
	localparam int SWEEP_CYCLES = 3 * REPETITIONS * (FRAME_LAST_SLOT + 1) * 2 * TOUCH_CLK_DIV;
	localparam int LONG_ACK_CYCLES = 70000;
	localparam int RELEASE_HOLD_CYCLES = 4 * TOUCH_CLK_DIV;
	localparam int TIMEOUT_CYCLES = 5 * SWEEP_CYCLES + LONG_ACK_CYCLES + 30000;
	localparam int SAMPLE_COUNT = 5;
	localparam int STALL_SAMPLE = 2;

	logic          cclk;
	logic          counter_rst;
	logic          touch_din;
	logic          sample_ack;
	logic          touch_clk;
	logic          touch_csb;
	logic          touch_dout;
	logic          sample_req;
	touch_sample_t sample;
	logic          frame_logged;
	touch_cmd_t    frame_cmd;
	logic [11:0]   frame_value;

	integer        seed = 32'h9f35;
	int            cycles = 0;
	int            frame_idx = 0;
	int            half_cnt = 0;
	int            sweeps_done = 0;
	int            sweeps_taken = 0;
	logic          clk_toggled = 1'b0;
	logic          prev_clk = 1'b0;
	logic          prev_req = 1'b0;
	logic          prev_ack = 1'b0;
	touch_sample_t held_sample = '0;
	touch_sample_t expected = '0;
	logic [11:0]   last_x = '0;
	logic [11:0]   last_y = '0;
	logic [11:0]   last_z = '0;

	touch_subsystem dut_i (
		.cclk        (cclk),
		.counter_rst (counter_rst),
		.touch_din   (touch_din),
		.sample_ack  (sample_ack),
		.touch_clk   (touch_clk),
		.touch_csb   (touch_csb),
		.touch_dout  (touch_dout),
		.sample_req  (sample_req),
		.sample      (sample)
	);

	tb_touch_panel panel_i (
		.cclk         (cclk),
		.touch_clk    (touch_clk),
		.touch_csb    (touch_csb),
		.touch_dout   (touch_dout),
		.touch_din    (touch_din),
		.frame_logged (frame_logged),
		.frame_cmd    (frame_cmd),
		.frame_value  (frame_value)
	);

	initial cclk = 1'b0;
	always #4 cclk = !cclk;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic verify_channel(input string what, input touch_channel_e got,
		input touch_channel_e exp);
		if (got !== exp) begin
			report_failure($sformatf("Error: %s is 0x%0h, expected 0x%0h", what, got, exp));
		end
	endtask

	task automatic compare_sample(input string what, input touch_sample_t got,
		input touch_sample_t exp);
		if (got !== exp) begin
			report_failure($sformatf("Error: %s is 0x%09h, expected 0x%09h", what, got, exp));
		end
	endtask

	task automatic expect_level(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			report_failure($sformatf("Error: %s is 0x%0h, expected 0x%0h", what, got, exp));
		end
	endtask

	// Below the window reads 0, above it is clipped to the window width
	function automatic logic [11:0] window_adjust(input logic [11:0] v, input logic [11:0] lo,
		input logic [11:0] hi);
		logic [12:0] diff;
		diff = {1'b0, v} - {1'b0, lo};
		if (diff[12]) begin
			return 12'd0;
		end
		if (diff[11:0] > hi) begin
			return hi;
		end
		return diff[11:0];
	endfunction

	function automatic touch_channel_e channel_for_frame(input int idx);
		if (idx < int'(REPETITIONS)) begin
			return CH_X;
		end
		if (idx < 2 * int'(REPETITIONS)) begin
			return CH_Y;
		end
		return CH_Z;
	endfunction

	// Command order and the reference sample of each sweep
	always @(posedge cclk) begin
		if (frame_logged) begin
			verify_channel("frame_cmd.channel", frame_cmd.channel, channel_for_frame(frame_idx));
			expect_level("frame_cmd.start", frame_cmd.start, 1'b1);
			expect_level("frame_cmd.mode", frame_cmd.mode, 1'b0);
			expect_level("frame_cmd.single_ended", frame_cmd.single_ended, 1'b1);
			expect_level("frame_cmd.power_down[1]", frame_cmd.power_down[1], 1'b0);
			expect_level("frame_cmd.power_down[0]", frame_cmd.power_down[0], 1'b0);
			if (frame_idx % REPETITIONS == REPETITIONS - 1) begin
				case (frame_idx / REPETITIONS)
					0: last_x = frame_value;
					1: last_y = frame_value;
					default: last_z = frame_value;
				endcase
			end
			if (frame_idx == 3 * int'(REPETITIONS) - 1) begin
				expected.x = window_adjust(last_x, X_ADJ_MIN, X_ADJ_MAX);
				expected.y = window_adjust(last_y, Y_ADJ_MIN, Y_ADJ_MAX);
				expected.z = last_z;
				sweeps_done = sweeps_done + 1;
				frame_idx = 0;
			end else begin
				frame_idx = frame_idx + 1;
			end
		end
	end

	// Timeout, serial clock period and handshake rules
	always @(posedge cclk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			report_failure($sformatf("Timeout: no result after %0d cycles", TIMEOUT_CYCLES));
		end
		if (counter_rst || touch_csb) begin
			half_cnt = 0;
			clk_toggled = 1'b0;
		end else begin
			half_cnt = half_cnt + 1;
			if (touch_clk != prev_clk) begin
				if (clk_toggled && (half_cnt != int'(TOUCH_CLK_DIV))) begin
					report_failure($sformatf("Error: touch_clk half period 0x%0h, expected 0x%0h",
						half_cnt, TOUCH_CLK_DIV));
				end
				clk_toggled = 1'b1;
				half_cnt = 0;
			end
		end
		if (!counter_rst) begin
			if (sample_req && prev_req) begin
				compare_sample("sample while sample_req high", sample, held_sample);
			end
			if (sample_req && !prev_req) begin
				expect_level("sample_ack at sample_req rise", sample_ack, 1'b0);
			end
			if (!sample_req && prev_req) begin
				expect_level("sample_ack before sample_req fall", prev_ack, 1'b1);
			end
		end
		prev_clk = touch_clk;
		prev_req = sample_req;
		prev_ack = sample_ack;
		held_sample = sample;
	end

	task automatic reset_phase();
		for (int i = 0; i < 3; i++) begin
			@(posedge cclk);
			if (i == 2) begin
				counter_rst <= 1'b0;
			end
			@(negedge cclk);
			expect_level("touch_csb", touch_csb, 1'b1);
			expect_level("touch_clk", touch_clk, 1'b0);
			expect_level("touch_dout", touch_dout, 1'b0);
			expect_level("sample_req", sample_req, 1'b0);
		end
		// Scanning starts on the first edge without reset
		@(posedge cclk);
		@(negedge cclk);
		expect_level("touch_csb", touch_csb, 1'b0);
	endtask

	// Once the port is found busy the bus must stay quiet
	task automatic hold_during_stall(input int count);
		logic stalled;
		stalled = 1'b0;
		repeat (count) begin
			@(posedge cclk);
			if (touch_csb) begin
				stalled = 1'b1;
			end else if (stalled) begin
				report_failure("A frame started while the port still held a sample");
			end
			if (stalled) begin
				expect_level("touch_clk in stall", touch_clk, 1'b0);
			end
		end
		if (!stalled) begin
			report_failure("The sweep did not stall while the port held a sample");
		end
	endtask

	initial begin
		int delay;
		counter_rst = 1'b1;
		sample_ack = 1'b0;
		reset_phase();
		for (int n = 0; n < SAMPLE_COUNT; n++) begin
			@(posedge cclk);
			while (!sample_req) @(posedge cclk);
			if (sweeps_done == sweeps_taken) begin
				report_failure("sample_req rose before a sweep had finished");
			end
			sweeps_taken = sweeps_done;
			compare_sample("sample", sample, expected);
			if (n == STALL_SAMPLE) begin
				hold_during_stall(LONG_ACK_CYCLES);
				// The sweep that met the busy port is dropped
				sweeps_taken = sweeps_done;
			end else begin
				delay = $random(seed) & 31;
				repeat (delay) @(posedge cclk);
			end
			sample_ack <= 1'b1;
			@(posedge cclk);
			while (sample_req) @(posedge cclk);
			if (n == STALL_SAMPLE) begin
				// Port stays taken until ack falls
				hold_during_stall(RELEASE_HOLD_CYCLES);
			end
			sample_ack <= 1'b0;
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* touch_subsystem.f */
touch_spi_pkg.sv
touch_coord_pkg.sv
touch_sclk_gen.sv
touch_frame_counter.sv
touch_cmd_shifter.sv
touch_resp_shifter.sv
touch_sample_port.sv
touchpad_controller.sv
touch_subsystem.sv
tb_touch_panel.sv
tb_touch_subsystem.sv

/* Makefile */
RTL = touch_spi_pkg.sv touch_coord_pkg.sv touch_sclk_gen.sv touch_frame_counter.sv \
	touch_cmd_shifter.sv touch_resp_shifter.sv touch_sample_port.sv \
	touchpad_controller.sv touch_subsystem.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only --top-module touch_subsystem $(RTL)

sim:
	verilator --binary --top-module tb_touch_subsystem -f touch_subsystem.f -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
